// File: npc.f
npc_pkg.sv
npc_bus_if.sv
npc_if_stage.sv
npc_regfile.sv
npc_id_stage.sv
npc_exu.sv
npc_core.sv
npc_core_chk.sv
npc_tb.sv

// File: npc_bus_if.sv
// stage to stage buses
`timescale 1ns/1ns

interface npc_fs_ds_if;
  import npc_pkg::*;

  logic fs_valid;
  pc_t fs_pc;
  inst_t fs_inst;
  // redirect request back to fetch
  logic br_taken;
  pc_t br_target;

  modport fs (output fs_valid, fs_pc, fs_inst, input br_taken, br_target);
  modport ds (input fs_valid, fs_pc, fs_inst, output br_taken, br_target);
endinterface

interface npc_ds_es_if;
  import npc_pkg::*;

  logic es_valid;
  pc_t es_pc;
  word_t rs1_data;
  word_t rs2_data;
  word_t imm;
  alu_op_t alu_op;
  br_func_t br_func;
  logic src_a_pc;
  logic src_b_imm;
  reg_addr_t rd;
  logic rd_wen;
  word_t es_result;

  modport ds (
    output es_valid, es_pc, rs1_data, rs2_data, imm, alu_op, br_func,
    output src_a_pc, src_b_imm, rd, rd_wen,
    input es_result
  );
  modport es (
    input es_valid, es_pc, rs1_data, rs2_data, imm, alu_op, br_func,
    input src_a_pc, src_b_imm, rd, rd_wen,
    output es_result
  );
endinterface

// File: npc_core.sv
// npc core top
`timescale 1ns/1ns

module npc_core #(
  parameter npc_pkg::pc_t PC_RESETVAL = 32'h8000_0000
) (
  input  logic               i_clk,
  input  logic               i_reset,
  // inst sram interface
  output logic               o_inst_sram_en,
  output npc_pkg::pc_t       o_inst_sram_addr,
  input  npc_pkg::inst_t     i_inst_sram_rdata,
  // retire trace
  output logic               o_commit_valid,
  output npc_pkg::pc_t       o_commit_pc,
  output npc_pkg::reg_addr_t o_commit_rd,
  output logic               o_commit_wen,
  output npc_pkg::word_t     o_commit_data
);
  import npc_pkg::*;

  npc_fs_ds_if fs_ds ();
  npc_ds_es_if ds_es ();

  npc_if_stage #(
    .PC_RESETVAL (PC_RESETVAL)
  ) u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .fs                (fs_ds.fs),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  npc_id_stage u_id_stage (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .fs      (fs_ds.ds),
    .es      (ds_es.ds)
  );

  npc_exu u_exu (
    .es (ds_es.es),
    .br (fs_ds.ds)
  );

  // instructions retire in the cycle they leave decode
  assign o_commit_valid = ds_es.es_valid;
  assign o_commit_pc = ds_es.es_pc;
  assign o_commit_rd = ds_es.rd;
  assign o_commit_wen = ds_es.rd_wen & (ds_es.rd != reg_addr_t'(0));
  assign o_commit_data = ds_es.es_result;

endmodule

// File: npc_core_chk.sv
// retire trace checker
`timescale 1ns/1ns

module npc_core_chk #(
  parameter npc_pkg::pc_t PC_RESETVAL = 32'h8000_0000
) (
  input logic               i_clk,
  input logic               i_reset,
  input logic               o_inst_sram_en,
  input npc_pkg::pc_t       o_inst_sram_addr,
  input logic               o_commit_valid,
  input npc_pkg::pc_t       o_commit_pc,
  input npc_pkg::reg_addr_t o_commit_rd,
  input logic               o_commit_wen,
  input npc_pkg::word_t     o_commit_data
);
  import npc_pkg::*;

  // expected retire at the head of the model trace
  logic head_ok = 1'b0;
  pc_t head_pc;
  reg_addr_t head_rd;
  logic head_wen;
  word_t head_data;
  logic head_taken;
  int head_test;

  // the last entry stays as head while the halt loop repeats it
  always @(posedge i_clk) begin
    if ((!head_ok || o_commit_valid) && npc_tb.exp_pc_q.size() != 0) begin
      head_ok <= 1'b1;
      head_pc <= npc_tb.exp_pc_q.pop_front();
      head_rd <= npc_tb.exp_rd_q.pop_front();
      head_wen <= npc_tb.exp_wen_q.pop_front();
      head_data <= npc_tb.exp_data_q.pop_front();
      head_taken <= npc_tb.exp_taken_q.pop_front();
      head_test <= npc_tb.exp_test_q.pop_front();
    end
  end

  a_quiet_in_reset: assert property (@(posedge i_clk) i_reset ##1 i_reset |-> !o_commit_valid)
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[0]++;
      $error("an instruction retired while reset was asserted");
    end

  a_first_fetch: assert property (@(posedge i_clk)
    $fell(i_reset) |-> o_inst_sram_en && (o_inst_sram_addr == PC_RESETVAL))
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[0]++;
      $error("mismatch reset first fetch expected %h actual %h", PC_RESETVAL,
             $sampled(o_inst_sram_addr));
    end

  a_pc: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid |-> head_ok && (o_commit_pc == head_pc))
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[$sampled(head_test)]++;
      $error("mismatch %s pc expected %h actual %h", npc_tb.test_name[$sampled(head_test)],
             $sampled(head_pc), $sampled(o_commit_pc));
    end

  a_wen: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid && head_ok |-> o_commit_wen == head_wen)
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[$sampled(head_test)]++;
      $error("mismatch %s write flag expected %b actual %b",
             npc_tb.test_name[$sampled(head_test)], $sampled(head_wen), $sampled(o_commit_wen));
    end

  a_rd_data: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid && head_ok && head_wen |->
      (o_commit_rd == head_rd) && (o_commit_data == head_data))
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[$sampled(head_test)]++;
      $error("mismatch %s rd/data expected x%0d %h actual x%0d %h",
             npc_tb.test_name[$sampled(head_test)], $sampled(head_rd), $sampled(head_data),
             $sampled(o_commit_rd), $sampled(o_commit_data));
    end

  // taken transfers cost exactly one bubble
  a_bubble: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid && head_ok && head_taken |=> !o_commit_valid ##1 o_commit_valid)
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[$sampled(head_test)]++;
      $error("a taken branch or jump was not followed by exactly one bubble cycle");
    end

  a_back_to_back: assert property (@(posedge i_clk) disable iff (i_reset)
    o_commit_valid && head_ok && !head_taken |=> o_commit_valid)
    else begin
      npc_tb.err_cnt = npc_tb.err_cnt + 1;
      npc_tb.test_errs[$sampled(head_test)]++;
      $error("a sequential instruction was not followed by a retire in the next cycle");
    end

endmodule

// File: npc_exu.sv
// execute unit
`timescale 1ns/1ns

module npc_exu (
  npc_ds_es_if.es es,
  npc_fs_ds_if.ds br
);
  import npc_pkg::*;

  word_t src_a;
  word_t src_b;
  word_t alu_result;
  word_t link;
  logic is_jump;
  logic rs_eq;
  logic rs_lt;
  logic taken;
  pc_t pc_target;
  pc_t reg_target;

  assign src_a = es.src_a_pc ? es.es_pc : es.rs1_data;
  assign src_b = es.src_b_imm ? es.imm : es.rs2_data;

  always_comb begin
    case (es.alu_op)
      ALU_ADD: alu_result = src_a + src_b;
      ALU_SUB: alu_result = src_a - src_b;
      ALU_AND: alu_result = src_a & src_b;
      ALU_OR: alu_result = src_a | src_b;
      ALU_XOR: alu_result = src_a ^ src_b;
      ALU_SLT: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
      ALU_SLL: alu_result = src_a << src_b[4:0];
      ALU_SRL: alu_result = src_a >> src_b[4:0];
      ALU_LUI: alu_result = src_b;
      default: alu_result = '0;
    endcase
  end

  // jumps write the return address instead of the alu result
  assign is_jump = (es.br_func == BR_JAL) || (es.br_func == BR_JALR);
  assign link = es.es_pc + 32'd4;
  assign es.es_result = is_jump ? link : alu_result;

  // branch compare on the register operands
  assign rs_eq = (es.rs1_data == es.rs2_data);
  assign rs_lt = $signed(es.rs1_data) < $signed(es.rs2_data);

  always_comb begin
    case (es.br_func)
      BR_EQ: taken = rs_eq;
      BR_NE: taken = ~rs_eq;
      BR_LT: taken = rs_lt;
      BR_JAL: taken = 1'b1;
      BR_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign pc_target = es.es_pc + es.imm;
  // jalr drops bit 0 of the sum
  assign reg_target = (es.rs1_data + es.imm) & ~32'd1;

  // fetch qualifies this with its own valid
  assign br.br_taken = taken;
  assign br.br_target = (es.br_func == BR_JALR) ? reg_target : pc_target;

endmodule

// File: npc_id_stage.sv
// instruction decode stage
`timescale 1ns/1ns

module npc_id_stage (
  input logic     i_clk,
  input logic     i_reset,
  npc_fs_ds_if.ds fs,
  npc_ds_es_if.ds es
);
  import npc_pkg::*;

  inst_t inst;
  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;

  word_t imm_i;
  word_t imm_u;
  word_t imm_b;
  word_t imm_j;

  // raw decode results before the legality check
  logic inst_ok;
  alu_op_t dec_alu_op;
  br_func_t dec_br_func;
  logic dec_src_a_pc;
  logic dec_src_b_imm;
  logic dec_rd_wen;
  word_t dec_imm;

  word_t rs1_data;
  word_t rs2_data;
  logic rf_wen;

  assign inst = fs.fs_inst;
  assign opcode = inst[6:0];
  assign rd = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign funct7 = inst[31:25];

  // immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    inst_ok = 1'b1;
    dec_alu_op = ALU_ADD;
    dec_br_func = BR_NONE;
    dec_src_a_pc = 1'b0;
    dec_src_b_imm = 1'b0;
    dec_rd_wen = 1'b0;
    dec_imm = imm_i;
    case (opcode)
      OP_LUI: begin
        dec_alu_op = ALU_LUI;
        dec_src_b_imm = 1'b1;
        dec_rd_wen = 1'b1;
        dec_imm = imm_u;
      end
      OP_AUIPC: begin
        dec_src_a_pc = 1'b1;
        dec_src_b_imm = 1'b1;
        dec_rd_wen = 1'b1;
        dec_imm = imm_u;
      end
      OP_IMM: begin
        dec_src_b_imm = 1'b1;
        dec_rd_wen = 1'b1;
        case (funct3)
          F3_ADD: dec_alu_op = ALU_ADD;
          F3_SLT: dec_alu_op = ALU_SLT;
          F3_XOR: dec_alu_op = ALU_XOR;
          F3_OR: dec_alu_op = ALU_OR;
          F3_AND: dec_alu_op = ALU_AND;
          // shifts by immediate are not in the subset
          default: inst_ok = 1'b0;
        endcase
      end
      OP_REG: begin
        dec_rd_wen = 1'b1;
        if (funct7 == F7_ALT) begin
          dec_alu_op = ALU_SUB;
          inst_ok = (funct3 == F3_ADD);
        end else begin
          inst_ok = (funct7 == F7_BASE);
          case (funct3)
            F3_ADD: dec_alu_op = ALU_ADD;
            F3_SLL: dec_alu_op = ALU_SLL;
            F3_SLT: dec_alu_op = ALU_SLT;
            F3_XOR: dec_alu_op = ALU_XOR;
            F3_SRL: dec_alu_op = ALU_SRL;
            F3_OR: dec_alu_op = ALU_OR;
            F3_AND: dec_alu_op = ALU_AND;
            // sltu is not in the subset
            default: inst_ok = 1'b0;
          endcase
        end
      end
      OP_BRANCH: begin
        dec_imm = imm_b;
        case (funct3)
          3'b000: dec_br_func = BR_EQ;
          3'b001: dec_br_func = BR_NE;
          3'b100: dec_br_func = BR_LT;
          default: inst_ok = 1'b0;
        endcase
      end
      OP_JAL: begin
        dec_br_func = BR_JAL;
        dec_rd_wen = 1'b1;
        dec_imm = imm_j;
      end
      OP_JALR: begin
        dec_br_func = BR_JALR;
        dec_rd_wen = 1'b1;
        inst_ok = (funct3 == 3'b000);
      end
      default: inst_ok = 1'b0;
    endcase
  end

  // writeback lands at the edge closing the retire cycle
  assign rf_wen = es.es_valid & es.rd_wen;

  npc_regfile u_regfile (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wen    (rf_wen),
    .i_waddr  (rd),
    .i_wdata  (es.es_result)
  );

  assign es.es_valid = fs.fs_valid;
  assign es.es_pc = fs.fs_pc;
  assign es.rs1_data = rs1_data;
  assign es.rs2_data = rs2_data;
  assign es.imm = dec_imm;
  assign es.alu_op = dec_alu_op;
  assign es.src_a_pc = dec_src_a_pc;
  assign es.src_b_imm = dec_src_b_imm;
  assign es.rd = rd;
  // unsupported encodings retire as a no-op
  assign es.rd_wen = dec_rd_wen & inst_ok;
  assign es.br_func = inst_ok ? dec_br_func : BR_NONE;

endmodule

// File: npc_if_stage.sv
// instruction fetch stage
`timescale 1ns/1ns

module npc_if_stage #(
  parameter npc_pkg::pc_t PC_RESETVAL = 32'h8000_0000
) (
  input  logic           i_clk,
  input  logic           i_reset,
  npc_fs_ds_if.fs        fs,
  // inst sram interface
  output logic           o_inst_sram_en,
  output npc_pkg::pc_t   o_inst_sram_addr,
  input  npc_pkg::inst_t i_inst_sram_rdata
);
  import npc_pkg::*;

  // pc of the request issued this cycle
  pc_t pc;
  pc_t seq_pc;
  pc_t next_pc;
  logic redirect;

  // pc and valid tag of the request whose data arrives this cycle
  pc_t req_pc;
  logic req_valid;

  // only a live instruction may redirect
  assign redirect = fs.fs_valid & fs.br_taken;

  assign seq_pc = pc + 32'd4;
  assign next_pc = redirect ? fs.br_target : seq_pc;

  // one request per cycle once reset is released
  assign o_inst_sram_en = ~i_reset;
  assign o_inst_sram_addr = pc;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc <= PC_RESETVAL;
      req_valid <= 1'b0;
    end else begin
      pc <= next_pc;
      // request made while a taken branch retires is the wrong path
      req_valid <= ~redirect;
    end
  end

  // the response carries the pc of its request
  always_ff @(posedge i_clk) begin
    req_pc <= pc;
  end

  assign fs.fs_valid = req_valid;
  assign fs.fs_pc = req_pc;
  assign fs.fs_inst = i_inst_sram_rdata;

endmodule

// File: npc_pkg.sv
// npc shared definitions
package npc_pkg;

  parameter int XLEN = 32;
  parameter int REG_ADDR_W = 5;
  parameter int REG_NUM = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [2:0] br_func_t;
  typedef logic [6:0] opcode_t;

  // major opcodes of the kept subset
  parameter opcode_t OP_LUI = 7'b0110111;
  parameter opcode_t OP_AUIPC = 7'b0010111;
  parameter opcode_t OP_IMM = 7'b0010011;
  parameter opcode_t OP_REG = 7'b0110011;
  parameter opcode_t OP_BRANCH = 7'b1100011;
  parameter opcode_t OP_JAL = 7'b1101111;
  parameter opcode_t OP_JALR = 7'b1100111;

  // alu operations
  parameter alu_op_t ALU_ADD = 4'd0;
  parameter alu_op_t ALU_SUB = 4'd1;
  parameter alu_op_t ALU_AND = 4'd2;
  parameter alu_op_t ALU_OR = 4'd3;
  parameter alu_op_t ALU_XOR = 4'd4;
  parameter alu_op_t ALU_SLT = 4'd5;
  parameter alu_op_t ALU_SLL = 4'd6;
  parameter alu_op_t ALU_SRL = 4'd7;
  // passes operand b through
  parameter alu_op_t ALU_LUI = 4'd8;

  // branch and jump kinds
  parameter br_func_t BR_NONE = 3'd0;
  parameter br_func_t BR_EQ = 3'd1;
  parameter br_func_t BR_NE = 3'd2;
  parameter br_func_t BR_LT = 3'd3;
  parameter br_func_t BR_JAL = 3'd4;
  parameter br_func_t BR_JALR = 3'd5;

  // funct3 of the register and immediate forms
  parameter logic [2:0] F3_ADD = 3'b000;
  parameter logic [2:0] F3_SLL = 3'b001;
  parameter logic [2:0] F3_SLT = 3'b010;
  parameter logic [2:0] F3_XOR = 3'b100;
  parameter logic [2:0] F3_SRL = 3'b101;
  parameter logic [2:0] F3_OR = 3'b110;
  parameter logic [2:0] F3_AND = 3'b111;

  parameter logic [6:0] F7_BASE = 7'b0000000;
  parameter logic [6:0] F7_ALT = 7'b0100000;

endpackage

// File: npc_regfile.sv
// general purpose register file
`timescale 1ns/1ns

module npc_regfile (
  input  logic               i_clk,
  input  logic               i_reset,
  input  npc_pkg::reg_addr_t i_raddr1,
  input  npc_pkg::reg_addr_t i_raddr2,
  output npc_pkg::word_t     o_rdata1,
  output npc_pkg::word_t     o_rdata2,
  input  logic               i_wen,
  input  npc_pkg::reg_addr_t i_waddr,
  input  npc_pkg::word_t     i_wdata
);
  import npc_pkg::*;

  word_t rf [REG_NUM];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < REG_NUM; i++) begin
        rf[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      // x0 is never written
      rf[i_waddr] <= i_wdata;
    end
  end

  // reads of x0 always see zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : rf[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : rf[i_raddr2];

endmodule

// File: npc_tb.sv
// npc core testbench
`timescale 1ns/1ns

module npc_tb;
  import npc_pkg::*;

  localparam pc_t BASE = 32'h8000_0000;
  localparam int MEM_WORDS = 128;
  localparam int NUM_TESTS = 6;
  // jal x0, 0 parks the core on itself
  localparam inst_t HALT = 32'h0000_006f;

  logic i_clk;
  logic i_reset;
  inst_t i_inst_sram_rdata;
  logic o_inst_sram_en;
  pc_t o_inst_sram_addr;
  logic o_commit_valid;
  pc_t o_commit_pc;
  reg_addr_t o_commit_rd;
  logic o_commit_wen;
  word_t o_commit_data;

  // expected retire trace for the bound checker
  pc_t exp_pc_q[$];
  reg_addr_t exp_rd_q[$];
  logic exp_wen_q[$];
  word_t exp_data_q[$];
  logic exp_taken_q[$];
  int exp_test_q[$];

  string test_name[NUM_TESTS];
  int test_start[NUM_TESTS];
  int test_end[NUM_TESTS];
  int test_errs[NUM_TESTS];
  int err_cnt;
  int ret_cnt;
  int prog_len;
  int n_fail;
  logic gen_done;
  logic [31:0] lfsr_state;
  inst_t mem[MEM_WORDS];

  npc_core #(.PC_RESETVAL(BASE)) dut0 (.*);

  bind npc_core npc_core_chk #(.PC_RESETVAL(PC_RESETVAL)) u_chk (
    .i_clk(i_clk), .i_reset(i_reset), .o_inst_sram_en(o_inst_sram_en),
    .o_inst_sram_addr(o_inst_sram_addr), .o_commit_valid(o_commit_valid),
    .o_commit_pc(o_commit_pc), .o_commit_rd(o_commit_rd),
    .o_commit_wen(o_commit_wen), .o_commit_data(o_commit_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // fibonacci lfsr stepped once per bit
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic inst_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic inst_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t b_type(logic [12:0] o, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OP_BRANCH};
  endfunction

  function automatic inst_t j_type(logic [20:0] o, reg_addr_t rd);
    return {o[20], o[10:1], o[11], o[19:12], rd, OP_JAL};
  endfunction

  // unused words hold nops whose immediate folds the whole address
  function automatic inst_t fill_word(pc_t addr);
    return i_type(addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0}, 5'd0, 3'd0, 5'd0, OP_IMM);
  endfunction

  function automatic inst_t read_mem(pc_t addr);
    pc_t off;
    off = addr - BASE;
    if (off < MEM_WORDS * 4) return mem[off >> 2];
    return fill_word(addr);
  endfunction

  task automatic put_inst(inst_t inst);
    mem[prog_len] = inst;
    prog_len++;
  endtask

  task automatic gen_program();
    logic [2:0] sel;
    logic [2:0] kind;
    logic [9:0] a;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(BASE + 4 * i);
    prog_len = 0;
    test_start[0] = 0;
    test_start[1] = 0;
    for (int n = 0; n < 24; n++) begin
      kind = 3'(rnd(3));
      sel = 3'(rnd(3));
      rd = reg_addr_t'(rnd(5));
      rs1 = reg_addr_t'(rnd(5));
      rs2 = reg_addr_t'(rnd(5));
      if (kind < 4) begin
        // sel 3 stands for sub
        if (sel == 3) put_inst(r_type(F7_ALT, rs2, rs1, F3_ADD, rd));
        else put_inst(r_type(F7_BASE, rs2, rs1, sel, rd));
      end else if (kind < 6) begin
        if (sel == 1 || sel == 3 || sel == 5) sel = F3_ADD;
        put_inst(i_type(12'(rnd(12)), rs1, sel, rd, OP_IMM));
      end else begin
        put_inst({20'(rnd(20)), rd, (kind == 6) ? OP_LUI : OP_AUIPC});
      end
    end
    test_start[2] = prog_len;
    put_inst(i_type(12'(rnd(12)), 5'd0, F3_ADD, 5'd0, OP_IMM));
    put_inst(r_type(F7_BASE, 5'd1, 5'd1, F3_ADD, 5'd0));
    put_inst({20'(rnd(20)), 5'd0, OP_LUI});
    put_inst(i_type(12'd7, 5'd0, F3_ADD, 5'd5, OP_IMM));
    put_inst(r_type(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd6));
    test_start[3] = prog_len;
    a = 10'(rnd(10));
    put_inst(i_type({2'b0, a}, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_inst(i_type({2'b0, a}, 5'd0, F3_ADD, 5'd2, OP_IMM));
    put_inst(i_type({2'b0, a} + 12'd5, 5'd0, F3_ADD, 5'd3, OP_IMM));
    // taken forms each skip one addi
    put_inst(b_type(13'd8, 5'd2, 5'd1, 3'b000));
    put_inst(i_type(12'd1, 5'd10, F3_ADD, 5'd10, OP_IMM));
    put_inst(b_type(13'd8, 5'd3, 5'd1, 3'b001));
    put_inst(i_type(12'd1, 5'd10, F3_ADD, 5'd10, OP_IMM));
    put_inst(b_type(13'd8, 5'd3, 5'd1, 3'b100));
    put_inst(i_type(12'd1, 5'd10, F3_ADD, 5'd10, OP_IMM));
    // untaken forms
    put_inst(b_type(13'd8, 5'd3, 5'd1, 3'b000));
    put_inst(b_type(13'd8, 5'd2, 5'd1, 3'b001));
    put_inst(b_type(13'd8, 5'd1, 5'd3, 3'b100));
    put_inst(j_type(21'd8, 5'd0));
    put_inst(i_type(12'd1, 5'd10, F3_ADD, 5'd10, OP_IMM));
    test_start[4] = prog_len;
    put_inst(j_type(21'd8, 5'd1));
    put_inst(i_type(12'd1, 5'd10, F3_ADD, 5'd10, OP_IMM));
    put_inst({20'd0, 5'd7, OP_AUIPC});
    // the odd offset loses bit 0 in the target
    put_inst(i_type(12'd13, 5'd7, 3'b000, 5'd3, OP_JALR));
    put_inst(i_type(12'd1, 5'd10, F3_ADD, 5'd10, OP_IMM));
    put_inst(i_type(12'd0, 5'd3, F3_ADD, 5'd4, OP_IMM));
    test_start[5] = prog_len;
    put_inst(i_type(12'(rnd(12)), 5'd0, F3_ADD, 5'd9, OP_IMM));
    for (int n = 0; n < 4; n++) begin
      put_inst(r_type(F7_BASE, 5'd8, 5'd9, F3_ADD, 5'd9));
      put_inst(i_type(12'(rnd(12)), 5'd9, F3_XOR, 5'd8, OP_IMM));
    end
    put_inst(HALT);
  endtask

  // isa model of the subset that records every retire
  task automatic run_model();
    word_t x [32];
    pc_t pc;
    pc_t npc;
    inst_t in;
    word_t a;
    word_t b;
    word_t res;
    word_t immi;
    logic wen;
    logic taken;
    int idx;
    int tid;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = BASE;
    for (int step = 0; step < 4 * MEM_WORDS; step++) begin
      idx = (pc - BASE) >> 2;
      in = mem[idx];
      a = x[in[19:15]];
      b = x[in[24:20]];
      immi = {{20{in[31]}}, in[31:20]};
      res = '0;
      wen = 1'b0;
      taken = 1'b0;
      npc = pc + 4;
      case (in[6:0])
        OP_LUI: {wen, res} = {1'b1, in[31:12], 12'b0};
        OP_AUIPC: {wen, res} = {1'b1, pc + {in[31:12], 12'b0}};
        OP_IMM, OP_REG: begin
          if (!in[5]) b = immi;
          wen = 1'b1;
          case (in[14:12])
            3'd0: res = (in[5] && in[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: res = a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
          endcase
        end
        OP_BRANCH: begin
          case (in[14:12])
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            default: taken = ($signed(a) < $signed(b));
          endcase
          if (taken) npc = pc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        end
        OP_JAL: begin
          {wen, taken, res} = {2'b11, pc + 32'd4};
          npc = pc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        end
        default: begin
          {wen, taken, res} = {2'b11, pc + 32'd4};
          npc = (a + immi) & ~32'd1;
        end
      endcase
      wen = wen && (in[11:7] != 5'd0);
      tid = 1;
      for (int k = 1; k < NUM_TESTS; k++) if (idx >= test_start[k]) tid = k;
      exp_pc_q.push_back(pc);
      exp_rd_q.push_back(in[11:7]);
      exp_wen_q.push_back(wen);
      exp_data_q.push_back(wen ? res : '0);
      exp_taken_q.push_back(taken);
      exp_test_q.push_back(tid);
      test_end[tid] = exp_pc_q.size();
      if (wen) x[in[11:7]] = res;
      if (in == HALT) break;
      pc = npc;
    end
  endtask

  always @(posedge i_clk) begin
    if (o_inst_sram_en) i_inst_sram_rdata <= read_mem(o_inst_sram_addr);
  end

  always @(negedge i_clk) begin
    if (!i_reset && o_commit_valid) ret_cnt++;
  end

  initial begin
    wait (gen_done);
    #((2 * prog_len + 16 + 8) * 20);
    $display("timeout: the core did not retire the expected instructions in time");
    $display("Regression failed");
    $finish;
  end

  initial begin
    i_reset = 1'b1;
    i_inst_sram_rdata = '0;
    {err_cnt, ret_cnt, n_fail} = '0;
    gen_done = 1'b0;
    lfsr_state = 32'hf5ef0c94;
    test_name = '{"reset", "alu", "x0", "branch", "jump", "dependent"};
    test_end = '{default: 0};
    test_errs = '{default: 0};
    gen_program();
    run_model();
    gen_done = 1'b1;
    repeat (16) @(posedge i_clk);
    i_reset <= 1'b0;
    for (int k = 0; k < NUM_TESTS; k++) begin
      while (ret_cnt < test_end[k]) @(posedge i_clk);
      // bubble checks of the last retire span two more cycles
      repeat (3) @(posedge i_clk);
      if (test_errs[k] != 0) n_fail++;
      $display("test %s: %s", test_name[k], (test_errs[k] == 0) ? "ok" : "FAILED");
    end
    $display("tests %0d passed %0d failed %0d assertion errors %0d",
             NUM_TESTS, NUM_TESTS - n_fail, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
